// File: logic/radio_pkg.sv
// Shared definitions for the radio block
// Control port widths, register map, reset values and channel state

package radio_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  typedef logic [19:0] ctrl_addr_t;
  typedef logic [31:0] ctrl_data_t;
  typedef logic [1:0]  ctrl_status_t;
  typedef logic [63:0] radio_time_t;
  typedef logic [7:0]  chan_offset_t;

  // Receive channel FSM
  typedef enum logic {
    RX_IDLE,
    RX_RUN
  } rx_state_t;

  // Response status codes
  localparam ctrl_status_t STATUS_OK       = 2'd0;
  localparam ctrl_status_t STATUS_ADDR_ERR = 2'd3;

  // ----------------------------------------
  // Address map
  // ----------------------------------------
  localparam int         WINDOW_ADDR_W    = 8;
  localparam ctrl_addr_t SHARED_BASE_ADDR = 20'h00000;
  // Channel n sits one 256-byte window above channel n-1
  localparam ctrl_addr_t RADIO_BASE_ADDR  = 20'h01000;

  // Shared window
  localparam chan_offset_t REG_COMPAT_NUM = 8'h00;
  localparam chan_offset_t REG_TIME_LO    = 8'h08;
  localparam chan_offset_t REG_TIME_HI    = 8'h0C;

  // Channel window
  localparam chan_offset_t REG_RX_SPP    = 8'h00;
  localparam chan_offset_t REG_RX_CMD    = 8'h04;
  localparam chan_offset_t REG_RX_STATUS = 8'h08;

  // Constant and reset values
  localparam ctrl_data_t COMPAT_NUM   = 32'h0000_0001;
  localparam ctrl_data_t RX_SPP_RESET = 32'd16;

endpackage

// File: logic/radio_ctrl_decoder.sv
// Control port address decoder
// Routes each request to the shared window or one channel window
// and merges the target acks into a single response

`timescale 1ns/1ns

module radio_ctrl_decoder #(
  parameter int NUM_PORTS = 2
) (
  input  logic                                  radio_clk,
  input  logic                                  radio_rst,
  input  logic                                  req_wr,
  input  logic                                  req_rd,
  input  radio_pkg::ctrl_addr_t                 req_addr,
  input  radio_pkg::ctrl_data_t                 req_data,
  output logic                                  resp_ack,
  output radio_pkg::ctrl_status_t               resp_status,
  output radio_pkg::ctrl_data_t                 resp_data,
  output logic                                  shared_req_wr,
  output logic                                  shared_req_rd,
  output radio_pkg::chan_offset_t               shared_req_addr,
  input  logic                                  shared_resp_ack,
  input  radio_pkg::ctrl_data_t                 shared_resp_data,
  output logic [NUM_PORTS-1:0]                  chan_req_wr,
  output logic [NUM_PORTS-1:0]                  chan_req_rd,
  output radio_pkg::chan_offset_t               chan_req_addr,
  output radio_pkg::ctrl_data_t                 chan_req_data,
  input  logic [NUM_PORTS-1:0]                  chan_resp_ack,
  input  radio_pkg::ctrl_data_t [NUM_PORTS-1:0] chan_resp_data
);
  import radio_pkg::*;

  localparam int PAGE_W = $bits(ctrl_addr_t) - WINDOW_ADDR_W;
  typedef logic [PAGE_W-1:0] page_t;

  page_t                req_page;
  logic                 req_any;
  logic                 hit_shared;
  logic [NUM_PORTS-1:0] hit_chan;
  logic                 err_q;
  logic                 err_ack;

  assign req_any  = req_wr | req_rd;
  assign req_page = req_addr[$bits(ctrl_addr_t)-1:WINDOW_ADDR_W];

  // Window select on the upper address bits
  always_comb begin
    hit_shared = (req_page == page_t'(SHARED_BASE_ADDR >> WINDOW_ADDR_W));
    for (int n = 0; n < NUM_PORTS; n++) begin
      hit_chan[n] = (req_page == page_t'((RADIO_BASE_ADDR >> WINDOW_ADDR_W) + n));
    end
  end

  // ----------------------------------------
  // Request stage
  // ----------------------------------------
  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      shared_req_wr <= 1'b0;
      shared_req_rd <= 1'b0;
      chan_req_wr   <= '0;
      chan_req_rd   <= '0;
      err_q         <= 1'b0;
      err_ack       <= 1'b0;
    end else begin
      shared_req_wr <= req_wr & hit_shared;
      shared_req_rd <= req_rd & hit_shared;
      chan_req_wr   <= {NUM_PORTS{req_wr}} & hit_chan;
      chan_req_rd   <= {NUM_PORTS{req_rd}} & hit_chan;
      // Unmapped address answers itself one cycle later, like a target
      err_q         <= req_any & ~hit_shared & ~(|hit_chan);
      err_ack       <= err_q;
    end
  end

  always_ff @(posedge radio_clk) begin
    if (req_any) begin
      shared_req_addr <= req_addr[WINDOW_ADDR_W-1:0];
      chan_req_addr   <= req_addr[WINDOW_ADDR_W-1:0];
      chan_req_data   <= req_data;
    end
  end

  // ----------------------------------------
  // Response merge
  // ----------------------------------------
  always_comb begin
    resp_ack    = shared_resp_ack | (|chan_resp_ack) | err_ack;
    resp_status = err_ack ? STATUS_ADDR_ERR : STATUS_OK;
    resp_data   = shared_resp_ack ? shared_resp_data : '0;
    for (int n = 0; n < NUM_PORTS; n++) begin
      if (chan_resp_ack[n]) begin
        resp_data = resp_data | chan_resp_data[n];
      end
    end
  end

  // One request in flight until its ack
  a_single_outstanding: assert property (@(posedge radio_clk) disable iff (radio_rst)
    req_any |=> !req_any [*2]);

  a_no_rd_wr: assert property (@(posedge radio_clk) disable iff (radio_rst)
    !(req_wr && req_rd));

endmodule

// File: logic/radio_shared_regs.sv
// Shared read-only registers
// Compatibility number and radio time with a latched upper half

`timescale 1ns/1ns

module radio_shared_regs (
  input  logic                    radio_clk,
  input  logic                    radio_rst,
  input  logic                    shared_req_wr,
  input  logic                    shared_req_rd,
  input  radio_pkg::chan_offset_t shared_req_addr,
  input  radio_pkg::radio_time_t  radio_time,
  output logic                    shared_resp_ack,
  output radio_pkg::ctrl_data_t   shared_resp_data
);
  import radio_pkg::*;

  ctrl_data_t time_hi_hold;

  // Every strobe gets an ack, writes have no effect
  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      shared_resp_ack <= 1'b0;
    end else begin
      shared_resp_ack <= shared_req_wr | shared_req_rd;
    end
  end

  always_ff @(posedge radio_clk) begin
    shared_resp_data <= '0;
    if (shared_req_rd) begin
      case (shared_req_addr)
        REG_COMPAT_NUM: shared_resp_data <= COMPAT_NUM;
        REG_TIME_LO: begin
          shared_resp_data <= radio_time[31:0];
          // Upper half frozen so a LO then HI read pair is coherent
          time_hi_hold     <= radio_time[63:32];
        end
        REG_TIME_HI:    shared_resp_data <= time_hi_hold;
        default: ;
      endcase
    end
  end

endmodule

// File: logic/radio_rx_channel.sv
// Receive channel control
// Channel registers, capture FSM, packet and burst framing, overflow count

`timescale 1ns/1ns

module radio_rx_channel #(
  parameter int ITEM_W = 32
) (
  input  logic                    radio_clk,
  input  logic                    radio_rst,
  input  logic                    req_wr,
  input  logic                    req_rd,
  input  radio_pkg::chan_offset_t req_addr,
  input  radio_pkg::ctrl_data_t   req_data,
  input  logic [ITEM_W-1:0]       radio_rx_data,
  input  logic                    radio_rx_stb,
  input  logic                    fifo_full,
  output logic                    resp_ack,
  output radio_pkg::ctrl_data_t   resp_data,
  output logic                    radio_rx_running,
  output logic                    push,
  output logic [ITEM_W-1:0]       push_data,
  output logic                    push_last,
  output logic                    push_eob
);
  import radio_pkg::*;

  rx_state_t   state;
  ctrl_data_t  spp;
  ctrl_data_t  remaining;
  ctrl_data_t  pkt_pos;
  logic [15:0] ovf_cnt;
  logic        cmd_wr;
  logic        stb_run;
  logic        overflow;

  assign cmd_wr   = req_wr && (req_addr == REG_RX_CMD);
  assign stb_run  = (state == RX_RUN) && radio_rx_stb;
  assign overflow = stb_run && fifo_full;

  // Store path straight from the strobe
  assign push      = stb_run && !fifo_full;
  assign push_data = radio_rx_data;
  assign push_eob  = (remaining == ctrl_data_t'(1));
  assign push_last = push_eob || (pkt_pos == spp);

  assign radio_rx_running = (state == RX_RUN);

  // ----------------------------------------
  // Capture FSM and counters
  // ----------------------------------------
  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      state     <= RX_IDLE;
      spp       <= RX_SPP_RESET;
      remaining <= '0;
      pkt_pos   <= '0;
      ovf_cnt   <= '0;
    end else begin
      if (req_wr && (req_addr == REG_RX_SPP)) begin
        spp <= req_data;
      end
      if (overflow) begin
        // Sample dropped and burst abandoned
        state <= RX_IDLE;
        if (ovf_cnt != '1) begin
          ovf_cnt <= ovf_cnt + 1'b1;
        end
      end else if (push) begin
        remaining <= remaining - 1'b1;
        pkt_pos   <= push_last ? ctrl_data_t'(1) : pkt_pos + 1'b1;
        if (push_eob) begin
          state <= RX_IDLE;
        end
      end
      // Command write overrides the strobe update
      if (cmd_wr) begin
        if (req_data != '0) begin
          state     <= RX_RUN;
          remaining <= req_data;
          pkt_pos   <= ctrl_data_t'(1);
        end else begin
          state <= RX_IDLE;
        end
      end
    end
  end

  // ----------------------------------------
  // Register reads
  // ----------------------------------------
  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      resp_ack <= 1'b0;
    end else begin
      resp_ack <= req_wr | req_rd;
    end
  end

  always_ff @(posedge radio_clk) begin
    resp_data <= '0;
    if (req_rd) begin
      case (req_addr)
        REG_RX_SPP:    resp_data <= spp;
        REG_RX_STATUS: resp_data <= {ovf_cnt, 15'd0, radio_rx_running};
        default: ;
      endcase
    end
  end

  // A running burst always has samples left to store
  a_run_has_samples: assert property (@(posedge radio_clk) disable iff (radio_rst)
    (state == RX_RUN) |-> (remaining != '0));

endmodule

// File: logic/radio_rx_fifo.sv
// Per-channel sample buffer
// Circular memory of data plus last/eob flags, registered valid/ready output

`timescale 1ns/1ns

module radio_rx_fifo #(
  parameter int ITEM_W          = 32,
  parameter int FIFO_DEPTH_LOG2 = 3
) (
  input  logic              radio_clk,
  input  logic              radio_rst,
  input  logic              push,
  input  logic [ITEM_W-1:0] push_data,
  input  logic              push_last,
  input  logic              push_eob,
  input  logic              rx_tready,
  output logic              fifo_full,
  output logic [ITEM_W-1:0] rx_tdata,
  output logic              rx_tlast,
  output logic              rx_teob,
  output logic              rx_tvalid
);

  localparam int DEPTH   = 2 ** FIFO_DEPTH_LOG2;
  localparam int ENTRY_W = ITEM_W + 2;

  logic [ENTRY_W-1:0]       mem [DEPTH];
  logic [FIFO_DEPTH_LOG2:0] wr_ptr;
  logic [FIFO_DEPTH_LOG2:0] rd_ptr;
  logic [FIFO_DEPTH_LOG2:0] fill;
  logic                     mem_empty;
  logic                     load;

  // Pointers carry one extra wrap bit
  assign fill      = wr_ptr - rd_ptr;
  assign fifo_full = fill[FIFO_DEPTH_LOG2];
  assign mem_empty = (wr_ptr == rd_ptr);

  // Refill the output stage when it is empty or being drained
  assign load = !mem_empty && (!rx_tvalid || rx_tready);

  always_ff @(posedge radio_clk) begin
    if (push) begin
      mem[wr_ptr[FIFO_DEPTH_LOG2-1:0]] <= {push_eob, push_last, push_data};
    end
  end

  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      rx_tvalid <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (load) begin
        rd_ptr    <= rd_ptr + 1'b1;
        rx_tvalid <= 1'b1;
      end else if (rx_tready) begin
        rx_tvalid <= 1'b0;
      end
    end
  end

  // Output stage holds its word until the transfer
  always_ff @(posedge radio_clk) begin
    if (load) begin
      {rx_teob, rx_tlast, rx_tdata} <= mem[rd_ptr[FIFO_DEPTH_LOG2-1:0]];
    end
  end

  a_no_push_when_full: assert property (@(posedge radio_clk) disable iff (radio_rst)
    push |-> !fifo_full);

endmodule

// File: logic/radio_block.sv
// Radio block top level
// Control decoder, shared registers, and one receive channel plus
// sample buffer per radio port

`timescale 1ns/1ns

module radio_block #(
  parameter int NUM_PORTS       = 2,
  parameter int ITEM_W          = 32,
  parameter int FIFO_DEPTH_LOG2 = 3
) (
  input  logic                          radio_clk,
  input  logic                          radio_rst,
  input  logic                          req_wr,
  input  logic                          req_rd,
  input  radio_pkg::ctrl_addr_t         req_addr,
  input  radio_pkg::ctrl_data_t         req_data,
  output logic                          resp_ack,
  output radio_pkg::ctrl_status_t       resp_status,
  output radio_pkg::ctrl_data_t         resp_data,
  input  radio_pkg::radio_time_t        radio_time,
  input  logic [NUM_PORTS*ITEM_W-1:0]   radio_rx_data,
  input  logic [NUM_PORTS-1:0]          radio_rx_stb,
  output logic [NUM_PORTS-1:0]          radio_rx_running,
  output logic [NUM_PORTS*ITEM_W-1:0]   rx_tdata,
  output logic [NUM_PORTS-1:0]          rx_tlast,
  output logic [NUM_PORTS-1:0]          rx_teob,
  output logic [NUM_PORTS-1:0]          rx_tvalid,
  input  logic [NUM_PORTS-1:0]          rx_tready
);
  import radio_pkg::*;

  logic                            shared_req_wr;
  logic                            shared_req_rd;
  chan_offset_t                    shared_req_addr;
  logic                            shared_resp_ack;
  ctrl_data_t                      shared_resp_data;
  logic [NUM_PORTS-1:0]            chan_req_wr;
  logic [NUM_PORTS-1:0]            chan_req_rd;
  chan_offset_t                    chan_req_addr;
  ctrl_data_t                      chan_req_data;
  logic [NUM_PORTS-1:0]            chan_resp_ack;
  ctrl_data_t [NUM_PORTS-1:0]      chan_resp_data;

  // ----------------------------------------
  // Register access
  // ----------------------------------------
  radio_ctrl_decoder #(
    .NUM_PORTS (NUM_PORTS)
  ) u_decoder (
    .radio_clk        (radio_clk),
    .radio_rst        (radio_rst),
    .req_wr           (req_wr),
    .req_rd           (req_rd),
    .req_addr         (req_addr),
    .req_data         (req_data),
    .resp_ack         (resp_ack),
    .resp_status      (resp_status),
    .resp_data        (resp_data),
    .shared_req_wr    (shared_req_wr),
    .shared_req_rd    (shared_req_rd),
    .shared_req_addr  (shared_req_addr),
    .shared_resp_ack  (shared_resp_ack),
    .shared_resp_data (shared_resp_data),
    .chan_req_wr      (chan_req_wr),
    .chan_req_rd      (chan_req_rd),
    .chan_req_addr    (chan_req_addr),
    .chan_req_data    (chan_req_data),
    .chan_resp_ack    (chan_resp_ack),
    .chan_resp_data   (chan_resp_data)
  );

  radio_shared_regs u_shared_regs (
    .radio_clk        (radio_clk),
    .radio_rst        (radio_rst),
    .shared_req_wr    (shared_req_wr),
    .shared_req_rd    (shared_req_rd),
    .shared_req_addr  (shared_req_addr),
    .radio_time       (radio_time),
    .shared_resp_ack  (shared_resp_ack),
    .shared_resp_data (shared_resp_data)
  );

  // ----------------------------------------
  // Receive channels
  // ----------------------------------------
  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_chan
    logic              push;
    logic [ITEM_W-1:0] push_data;
    logic              push_last;
    logic              push_eob;
    logic              fifo_full;

    radio_rx_channel #(
      .ITEM_W (ITEM_W)
    ) u_channel (
      .radio_clk        (radio_clk),
      .radio_rst        (radio_rst),
      .req_wr           (chan_req_wr[i]),
      .req_rd           (chan_req_rd[i]),
      .req_addr         (chan_req_addr),
      .req_data         (chan_req_data),
      .radio_rx_data    (radio_rx_data[i*ITEM_W +: ITEM_W]),
      .radio_rx_stb     (radio_rx_stb[i]),
      .fifo_full        (fifo_full),
      .resp_ack         (chan_resp_ack[i]),
      .resp_data        (chan_resp_data[i]),
      .radio_rx_running (radio_rx_running[i]),
      .push             (push),
      .push_data        (push_data),
      .push_last        (push_last),
      .push_eob         (push_eob)
    );

    radio_rx_fifo #(
      .ITEM_W          (ITEM_W),
      .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) u_fifo (
      .radio_clk (radio_clk),
      .radio_rst (radio_rst),
      .push      (push),
      .push_data (push_data),
      .push_last (push_last),
      .push_eob  (push_eob),
      .rx_tready (rx_tready[i]),
      .fifo_full (fifo_full),
      .rx_tdata  (rx_tdata[i*ITEM_W +: ITEM_W]),
      .rx_tlast  (rx_tlast[i]),
      .rx_teob   (rx_teob[i]),
      .rx_tvalid (rx_tvalid[i])
    );
  end

endmodule

// File: dv/radio_block_tb.sv
// Testbench for the radio block
// Clock and reset, LCG stimulus, control bus tasks, per-channel stream
// model with a monitor, and the directed-random tests

`timescale 1ns/1ns

module radio_block_tb;
  import radio_pkg::*;

  localparam int          NUM_PORTS       = 2;
  localparam int          ITEM_W          = 32;
  localparam int          FIFO_DEPTH_LOG2 = 3;
  localparam int          DEPTH           = 2 ** FIFO_DEPTH_LOG2;
  localparam logic [31:0] SEED            = 32'd17363;
  localparam int          ACK_TIMEOUT     = 20;
  localparam int          DRAIN_TIMEOUT   = 400;

  // Ready pattern per channel
  localparam int READY_LOW    = 0;
  localparam int READY_HIGH   = 1;
  localparam int READY_RANDOM = 2;

  // Strobe pattern during a capture
  localparam int STB_RANDOM = 0;
  localparam int STB_EVERY  = 1;
  localparam int STB_FOURTH = 2;

  logic                        radio_clk = 1'b0;
  logic                        radio_rst;
  logic                        req_wr;
  logic                        req_rd;
  ctrl_addr_t                  req_addr;
  ctrl_data_t                  req_data;
  logic                        resp_ack;
  ctrl_status_t                resp_status;
  ctrl_data_t                  resp_data;
  radio_time_t                 radio_time;
  logic [NUM_PORTS*ITEM_W-1:0] radio_rx_data;
  logic [NUM_PORTS-1:0]        radio_rx_stb;
  logic [NUM_PORTS-1:0]        radio_rx_running;
  logic [NUM_PORTS*ITEM_W-1:0] rx_tdata;
  logic [NUM_PORTS-1:0]        rx_tlast;
  logic [NUM_PORTS-1:0]        rx_teob;
  logic [NUM_PORTS-1:0]        rx_tvalid;
  logic [NUM_PORTS-1:0]        rx_tready;

  // Expected stream words per channel, packed as {eob, last, data}
  logic [ITEM_W+1:0] exp_q [NUM_PORTS][$];
  logic [ITEM_W+1:0] mon_word;
  int                got_count [NUM_PORTS];
  int                ready_mode [NUM_PORTS];
  logic [31:0]       stim_seed        = SEED;
  logic [31:0]       ready_seed;
  int                errors           = 0;
  int                checks           = 0;
  int                tests_run        = 0;
  int                test_errors_base = 0;
  bit                run_over         = 1'b0;

  radio_block #(
    .NUM_PORTS       (NUM_PORTS),
    .ITEM_W          (ITEM_W),
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
  ) u_radio_block (
    .radio_clk        (radio_clk),
    .radio_rst        (radio_rst),
    .req_wr           (req_wr),
    .req_rd           (req_rd),
    .req_addr         (req_addr),
    .req_data         (req_data),
    .resp_ack         (resp_ack),
    .resp_status      (resp_status),
    .resp_data        (resp_data),
    .radio_time       (radio_time),
    .radio_rx_data    (radio_rx_data),
    .radio_rx_stb     (radio_rx_stb),
    .radio_rx_running (radio_rx_running),
    .rx_tdata         (rx_tdata),
    .rx_tlast         (rx_tlast),
    .rx_teob          (rx_teob),
    .rx_tvalid        (rx_tvalid),
    .rx_tready        (rx_tready)
  );

  always #2 radio_clk = ~radio_clk;

  // ----------------------------------------
  // Random numbers
  // ----------------------------------------
  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_random();
    stim_seed = lcg_step(stim_seed);
    return stim_seed;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    logic [31:0] r;
    r = next_random();
    return lo + int'((r >> 8) % 32'(hi - lo + 1));
  endfunction

  function automatic ctrl_addr_t chan_addr(input int ch, input chan_offset_t off);
    return RADIO_BASE_ADDR + ctrl_addr_t'(ch * 256) + ctrl_addr_t'(off);
  endfunction

  function automatic ctrl_addr_t shared_addr(input chan_offset_t off);
    return SHARED_BASE_ADDR + ctrl_addr_t'(off);
  endfunction

  // ----------------------------------------
  // Reporting
  // ----------------------------------------
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    checks++;
    assert (got === expected) else begin
      errors++;
      $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, expected);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("error at %0t: %s", $time, what);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    $display("test %0d %s: %0d errors", tests_run, name, errors - test_errors_base);
    test_errors_base = errors;
  endtask

  task automatic end_run();
    if (!run_over) begin
      run_over = 1'b1;
      $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0) begin
        $display("Result: PASSED");
      end else begin
        $display("Result: FAILED");
      end
      $finish;
    end
  endtask

  // ----------------------------------------
  // Control bus
  // ----------------------------------------
  task automatic ctrl_access(input logic wr, input ctrl_addr_t addr, input ctrl_data_t wdata,
                             input ctrl_status_t exp_status, output ctrl_data_t rdata);
    int waited;
    @(posedge radio_clk);
    #1;
    req_wr   = wr;
    req_rd   = !wr;
    req_addr = addr;
    req_data = wdata;
    @(posedge radio_clk);
    #1;
    req_wr = 1'b0;
    req_rd = 1'b0;
    waited = 1;
    @(negedge radio_clk);
    while (!resp_ack && waited < ACK_TIMEOUT) begin
      @(negedge radio_clk);
      waited++;
    end
    rdata = resp_data;
    if (!resp_ack) begin
      report_failure($sformatf("no ack within %0d cycles for address %05h", ACK_TIMEOUT, addr));
      end_run();
    end else begin
      check_value("ack latency", 64'(waited), 64'd2);
      check_value("resp_status", 64'(resp_status), 64'(exp_status));
    end
  endtask

  task automatic ctrl_write(input ctrl_addr_t addr, input ctrl_data_t data,
                            input ctrl_status_t exp_status);
    ctrl_data_t unused;
    ctrl_access(1'b1, addr, data, exp_status, unused);
  endtask

  task automatic ctrl_read(input ctrl_addr_t addr, input ctrl_status_t exp_status,
                           output ctrl_data_t data);
    ctrl_access(1'b0, addr, '0, exp_status, data);
  endtask

  task automatic read_expect(input ctrl_addr_t addr, input ctrl_data_t expected,
                             input string name);
    ctrl_data_t data;
    ctrl_read(addr, STATUS_OK, data);
    check_value(name, 64'(data), 64'(expected));
  endtask

  // ----------------------------------------
  // Stream side
  // ----------------------------------------
  initial begin
    ready_seed = ~SEED;
    rx_tready  = '0;
    forever begin
      @(posedge radio_clk);
      #1;
      for (int ch = 0; ch < NUM_PORTS; ch++) begin
        case (ready_mode[ch])
          READY_LOW:  rx_tready[ch] = 1'b0;
          READY_HIGH: rx_tready[ch] = 1'b1;
          default: begin
            // Ready three cycles out of four on average
            ready_seed    = lcg_step(ready_seed);
            rx_tready[ch] = (ready_seed[17:16] != 2'b00);
          end
        endcase
      end
    end
  end

  // Monitor samples mid-cycle, where valid, ready and data are settled
  initial begin
    forever begin
      @(negedge radio_clk);
      if (!radio_rst) begin
        for (int ch = 0; ch < NUM_PORTS; ch++) begin
          if (rx_tvalid[ch] && rx_tready[ch]) begin
            got_count[ch]++;
            if (exp_q[ch].size() == 0) begin
              report_failure($sformatf("channel %0d delivered an unexpected word", ch));
            end else begin
              mon_word = exp_q[ch].pop_front();
              check_value($sformatf("rx_tdata[%0d]", ch),
                          64'(rx_tdata[ch*ITEM_W +: ITEM_W]), 64'(mon_word[ITEM_W-1:0]));
              check_value($sformatf("rx_tlast[%0d]", ch),
                          64'(rx_tlast[ch]), 64'(mon_word[ITEM_W]));
              check_value($sformatf("rx_teob[%0d]", ch),
                          64'(rx_teob[ch]), 64'(mon_word[ITEM_W+1]));
            end
          end
        end
      end
    end
  end

  // Programs a burst and strobes it in; the first keep samples enter the model
  task automatic drive_capture(input int ch, input int n, input int spp, input int stb_mode,
                               input int keep);
    logic [31:0] r;
    logic        stb;
    logic        last;
    int          k;
    int          cycles;
    ctrl_write(chan_addr(ch, REG_RX_SPP), ctrl_data_t'(spp), STATUS_OK);
    ctrl_write(chan_addr(ch, REG_RX_CMD), ctrl_data_t'(n), STATUS_OK);
    k      = 0;
    cycles = 0;
    while (k < n && cycles < n * 8 + 16) begin
      @(posedge radio_clk);
      #1;
      r = next_random();
      case (stb_mode)
        STB_EVERY:  stb = 1'b1;
        STB_FOURTH: stb = (cycles % 4 == 0);
        default:    stb = r[20];
      endcase
      radio_rx_stb[ch] = stb;
      if (stb) begin
        k++;
        radio_rx_data[ch*ITEM_W +: ITEM_W] = next_random();
        last = (k % spp == 0) || (k == n);
        if (k <= keep) begin
          exp_q[ch].push_back({(k == n), last, radio_rx_data[ch*ITEM_W +: ITEM_W]});
        end
      end
      cycles++;
    end
    @(posedge radio_clk);
    #1;
    radio_rx_stb = '0;
    if (k < n) begin
      report_failure($sformatf("only %0d of %0d strobes were driven", k, n));
    end
  endtask

  task automatic wait_drain(input int ch);
    int waited;
    waited = 0;
    @(negedge radio_clk);
    while ((exp_q[ch].size() != 0 || rx_tvalid[ch]) && waited < DRAIN_TIMEOUT) begin
      @(negedge radio_clk);
      waited++;
    end
    if (exp_q[ch].size() != 0 || rx_tvalid[ch]) begin
      report_failure($sformatf("channel %0d stream did not drain, %0d words missing",
                               ch, exp_q[ch].size()));
      end_run();
    end
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic after_reset_test();
    @(negedge radio_clk);
    check_value("resp_ack", 64'(resp_ack), 64'd0);
    check_value("rx_tvalid", 64'(rx_tvalid), 64'd0);
    check_value("radio_rx_running", 64'(radio_rx_running), 64'd0);
    read_expect(shared_addr(REG_COMPAT_NUM), COMPAT_NUM, "REG_COMPAT_NUM");
    for (int ch = 0; ch < NUM_PORTS; ch++) begin
      read_expect(chan_addr(ch, REG_RX_SPP), RX_SPP_RESET, $sformatf("REG_RX_SPP[%0d]", ch));
      read_expect(chan_addr(ch, REG_RX_STATUS), '0, $sformatf("REG_RX_STATUS[%0d]", ch));
    end
    finish_test("after reset");
  endtask

  task automatic radio_time_test();
    radio_time_t t_first;
    ctrl_data_t  lo;
    ctrl_data_t  hi;
    logic [31:0] r;
    hi      = next_random();
    lo      = next_random();
    t_first = {hi, lo};
    @(posedge radio_clk);
    #1;
    radio_time = t_first;
    ctrl_read(shared_addr(REG_TIME_LO), STATUS_OK, lo);
    @(posedge radio_clk);
    #1;
    radio_time = ~t_first;
    ctrl_read(shared_addr(REG_TIME_HI), STATUS_OK, hi);
    check_value("radio time from LO then HI", {hi, lo}, t_first);
    // Bit 19 set lands far above every window
    r = next_random();
    ctrl_read({1'b1, r[18:0]}, STATUS_ADDR_ERR, lo);
    check_value("resp_data on unmapped read", 64'(lo), 64'd0);
    r = next_random();
    ctrl_write({1'b1, r[18:0]}, r, STATUS_ADDR_ERR);
    finish_test("radio time and errors");
  endtask

  task automatic register_independence_test();
    ctrl_data_t spp_val [NUM_PORTS];
    for (int ch = 0; ch < NUM_PORTS; ch++) begin
      spp_val[ch] = next_random();
      ctrl_write(chan_addr(ch, REG_RX_SPP), spp_val[ch], STATUS_OK);
    end
    for (int ch = 0; ch < NUM_PORTS; ch++) begin
      read_expect(chan_addr(ch, REG_RX_SPP), spp_val[ch], $sformatf("REG_RX_SPP[%0d]", ch));
      read_expect(chan_addr(ch, REG_RX_CMD), '0, $sformatf("REG_RX_CMD[%0d]", ch));
    end
    finish_test("register independence");
  endtask

  task automatic capture_framing_test();
    int ch;
    int n;
    for (int burst = 0; burst < 3; burst++) begin
      ch = rand_range(0, NUM_PORTS - 1);
      n  = rand_range(1, 40);
      drive_capture(ch, n, rand_range(1, 8), STB_RANDOM, n);
      wait_drain(ch);
      check_value($sformatf("radio_rx_running[%0d]", ch), 64'(radio_rx_running[ch]), 64'd0);
    end
    finish_test("capture framing");
  endtask

  task automatic backpressure_test();
    int ch;
    int n;
    for (int burst = 0; burst < 2; burst++) begin
      ch             = rand_range(0, NUM_PORTS - 1);
      n              = rand_range(8, 40);
      ready_mode[ch] = READY_RANDOM;
      drive_capture(ch, n, rand_range(1, 8), STB_FOURTH, n);
      wait_drain(ch);
      ready_mode[ch] = READY_HIGH;
      read_expect(chan_addr(ch, REG_RX_STATUS), '0, $sformatf("REG_RX_STATUS[%0d]", ch));
    end
    finish_test("back-pressure");
  endtask

  task automatic overflow_test();
    int ch;
    ch             = rand_range(0, NUM_PORTS - 1);
    ready_mode[ch] = READY_LOW;
    got_count[ch]  = 0;
    // Buffer plus output stage hold DEPTH + 1 words, the next strobe overflows
    drive_capture(ch, DEPTH + 6, rand_range(1, 4), STB_EVERY, DEPTH + 1);
    check_value($sformatf("radio_rx_running[%0d]", ch), 64'(radio_rx_running[ch]), 64'd0);
    // Overflow count 1 in the upper half, running bit clear
    read_expect(chan_addr(ch, REG_RX_STATUS), ctrl_data_t'(1) << 16,
                $sformatf("REG_RX_STATUS[%0d]", ch));
    ready_mode[ch] = READY_HIGH;
    wait_drain(ch);
    check_value($sformatf("words delivered on channel %0d", ch),
                64'(got_count[ch]), 64'(DEPTH + 1));
    finish_test("overflow");
  endtask

  initial begin
    radio_rst     = 1'b1;
    req_wr        = 1'b0;
    req_rd        = 1'b0;
    req_addr      = '0;
    req_data      = '0;
    radio_time    = '0;
    radio_rx_data = '0;
    radio_rx_stb  = '0;
    for (int ch = 0; ch < NUM_PORTS; ch++) begin
      ready_mode[ch] = READY_HIGH;
      got_count[ch]  = 0;
    end
    repeat (2) @(posedge radio_clk);
    #1;
    radio_rst = 1'b0;
    after_reset_test();
    radio_time_test();
    register_independence_test();
    capture_framing_test();
    backpressure_test();
    overflow_test();
    end_run();
  end

endmodule

// File: tb.f
logic/radio_pkg.sv
logic/radio_ctrl_decoder.sv
logic/radio_shared_regs.sv
logic/radio_rx_channel.sv
logic/radio_rx_fifo.sv
logic/radio_block.sv
dv/radio_block_tb.sv

// File: Makefile
# Verilator flow for the radio block testbench
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= radio_block_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || { echo "No result found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
